/* src/tetrisPkg.sv */
//------------------------------
// tetris shared definitions
// board size, piece types, key codes,
// mover states and shape offset table
//------------------------------
`default_nettype none

package tetrisPkg;

	localparam int boardRows = 20; // playfield height
	localparam int boardCols = 10; // playfield width

	typedef logic [boardCols-1:0] boardRow_t; // bit n is column n
	typedef boardRow_t [boardRows-1:0] board_t; // index 0 is the top row
	typedef logic signed [5:0] coord_t; // rows go negative above the board
	typedef logic [2:0] shape_t; // 0 none, then O I T S Z J L
	typedef logic [1:0] rot_t; // quarter turns

	typedef struct packed {
		coord_t row;
		coord_t col;
	} cell_t;

	// c3 first so the struct lines up with cell_t [3:0]
	typedef struct packed {
		cell_t c3;
		cell_t c2;
		cell_t c1;
		cell_t c0;
	} pieceCells_t;

	typedef struct packed {
		coord_t row; // anchor row
		coord_t col; // anchor column
		shape_t shape;
		rot_t rot;
	} pieceState_t;

	typedef struct packed {
		logic moveLeft; // one cycle
		logic moveRight; // one cycle
		logic rotate; // one cycle
		logic drop; // held level
	} keyCmd_t;

	localparam logic [7:0] keyA = 8'h04; // left
	localparam logic [7:0] keyD = 8'h07; // right
	localparam logic [7:0] keyW = 8'h1a; // rotate
	localparam logic [7:0] keyS = 8'h16; // soft drop
	localparam logic [7:0] keySpace = 8'h2c; // also drop

	localparam coord_t spawnRow = -3; // above the visible rows
	localparam coord_t spawnCol = 4;

	// ------------------------------
	// offsets per shape, rotation, cell as {row, col}
	localparam coord_t shapeOffsets [1:7][0:3][0:3][0:1] = '{
		'{'{'{0, 0}, '{0, 1}, '{1, 0}, '{1, 1}}, // O
		  '{'{0, 0}, '{0, 1}, '{1, 0}, '{1, 1}},
		  '{'{0, 0}, '{0, 1}, '{1, 0}, '{1, 1}},
		  '{'{0, 0}, '{0, 1}, '{1, 0}, '{1, 1}}},
		'{'{'{0, -1}, '{0, 0}, '{0, 1}, '{0, 2}}, // I
		  '{'{0, 0}, '{-1, 0}, '{2, 0}, '{1, 0}},
		  '{'{0, -1}, '{0, 0}, '{0, 1}, '{0, 2}},
		  '{'{0, 0}, '{-1, 0}, '{2, 0}, '{1, 0}}},
		'{'{'{0, -1}, '{0, 0}, '{1, 0}, '{0, 1}}, // T
		  '{'{0, 0}, '{-1, 0}, '{1, 0}, '{0, 1}},
		  '{'{0, -1}, '{-1, 0}, '{0, 0}, '{0, 1}},
		  '{'{0, -1}, '{-1, 0}, '{1, 0}, '{0, 0}}},
		'{'{'{1, -1}, '{0, 0}, '{1, 0}, '{0, 1}}, // S
		  '{'{0, 0}, '{-1, 0}, '{1, 1}, '{0, 1}},
		  '{'{1, -1}, '{0, 0}, '{1, 0}, '{0, 1}},
		  '{'{0, 0}, '{-1, 0}, '{1, 1}, '{0, 1}}},
		'{'{'{0, -1}, '{0, 0}, '{1, 0}, '{1, 1}}, // Z
		  '{'{0, -1}, '{-1, 0}, '{1, -1}, '{0, 0}},
		  '{'{0, -1}, '{0, 0}, '{1, 0}, '{1, 1}},
		  '{'{0, -1}, '{-1, 0}, '{1, -1}, '{0, 0}}},
		'{'{'{1, -1}, '{-1, 0}, '{1, 0}, '{0, 0}}, // J
		  '{'{0, -1}, '{0, 0}, '{1, 1}, '{0, 1}},
		  '{'{0, 0}, '{-1, 0}, '{1, 0}, '{-1, 1}},
		  '{'{0, -1}, '{-1, -1}, '{0, 0}, '{0, 1}}},
		'{'{'{0, 0}, '{-1, 0}, '{1, 0}, '{1, 1}}, // L
		  '{'{0, -1}, '{-1, 1}, '{0, 0}, '{0, 1}},
		  '{'{-1, -1}, '{-1, 0}, '{1, 0}, '{0, 0}},
		  '{'{0, -1}, '{0, 0}, '{1, -1}, '{0, 1}}}
	};

	typedef enum logic [2:0] {
		idle, // just out of reset
		spawn, // load a new piece
		fall, // gravity and player moves
		dwell, // resting, lock delay running
		over // top row filled
	} moverState_t;

endpackage

`default_nettype wire

/* src/keyDecoder.sv */
//------------------------------
// key decoder
// raw keycode to one-shot move and
// rotate pulses plus a drop level
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module keyDecoder import tetrisPkg::*;
(
	input wire Reset, // clock
	input wire frame_clk, // async reset, active high
	input wire [7:0] keycode,
	output keyCmd_t keyCmd,
	output logic startGame
);

	logic [7:0] prevKey; // keycode seen last cycle
	logic newKey; // code differs from last cycle

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
			prevKey <= '0;
		else
			prevKey <= keycode;
	end

	assign newKey = (keycode != prevKey);

	always_comb
	begin
		keyCmd.moveLeft = newKey && (keycode == keyA); // first cycle of A only
		keyCmd.moveRight = newKey && (keycode == keyD);
		keyCmd.rotate = newKey && (keycode == keyW);
		keyCmd.drop = (keycode == keyS) || (keycode == keySpace); // level while held
	end

	assign startGame = (keycode != 8'h00); // any key at all

endmodule

`default_nettype wire

/* src/pieceShape.sv */
//------------------------------
// piece shape lookup
// anchor plus table offsets gives
// the four board cells of a piece
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module pieceShape import tetrisPkg::*;
(
	input wire pieceState_t piece,
	output pieceCells_t cells
);

	cell_t [3:0] cellArr; // same bits as cells

	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (piece.shape == shape_t'(0))
			begin
				cellArr[i].row = coord_t'(-20); // no piece yet, park it off the board
				cellArr[i].col = coord_t'(-20);
			end
			else
			begin
				cellArr[i].row = piece.row + shapeOffsets[piece.shape][piece.rot][i][0];
				cellArr[i].col = piece.col + shapeOffsets[piece.shape][piece.rot][i][1];
			end
		end
	end

	assign cells = cellArr; // c0 is cellArr[0]

endmodule

`default_nettype wire

/* src/collisionCheck.sv */
//------------------------------
// collision check
// piece against walls, floor and the
// landed cells, plus row status flags
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module collisionCheck import tetrisPkg::*;
(
	input wire pieceCells_t cells, // current piece
	input wire pieceCells_t rotCells, // piece after one more turn
	input wire board_t fallenBlocks,
	output logic blockedLeft,
	output logic blockedRight,
	output logic blockedDown,
	output logic blockedRot,
	output logic lineBreak,
	output logic gameOver
);

	cell_t [3:0] cellArr;
	cell_t [3:0] rotArr;

	assign cellArr = cells;
	assign rotArr = rotCells;

	// ------------------------------
	// contact tests, all four cells
	always_comb
	begin
		int r;
		int c;
		blockedLeft = 1'b0;
		blockedRight = 1'b0;
		blockedDown = 1'b0;
		blockedRot = 1'b0;
		for (int i = 0; i < 4; i++)
		begin
			r = cellArr[i].row; // sign extends
			c = cellArr[i].col;
			if (c <= 0)
				blockedLeft = 1'b1; // left wall
			else if (r >= 0 && r < boardRows && c < boardCols && fallenBlocks[r][c-1])
				blockedLeft = 1'b1;
			if (c >= boardCols - 1)
				blockedRight = 1'b1; // right wall
			else if (r >= 0 && r < boardRows && c >= 0 && fallenBlocks[r][c+1])
				blockedRight = 1'b1;
			if (r >= boardRows - 1)
				blockedDown = 1'b1; // floor
			else if (r >= -1 && c >= 0 && c < boardCols && fallenBlocks[r+1][c])
				blockedDown = 1'b1; // landed cell just below
			r = rotArr[i].row;
			c = rotArr[i].col;
			if (c < 0 || c >= boardCols || r >= boardRows)
				blockedRot = 1'b1; // turn would leave the board
			else if (r >= 0 && fallenBlocks[r][c])
				blockedRot = 1'b1; // turn would overlap
		end
	end

	// ------------------------------
	// board status
	always_comb
	begin
		lineBreak = 1'b0;
		for (int k = 0; k < boardRows; k++)
		begin
			if (&fallenBlocks[k])
				lineBreak = 1'b1; // complete row somewhere
		end
	end

	assign gameOver = |fallenBlocks[0]; // stack reached the top

endmodule

`default_nettype wire

/* src/pieceMover.sv */
//------------------------------
// piece mover FSM
// spawn, gravity, moves, rotation,
// lock delay and next shape choice
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module pieceMover import tetrisPkg::*;
#(
	parameter int gravityBase = 60, // fall period at difficulty 0
	parameter int dropStep = 10 // count step while drop held
)
(
	input wire Reset, // clock
	input wire frame_clk, // async reset, active high
	input wire keyCmd_t keyCmd,
	input wire [3:0] difficulty,
	input wire blockedLeft,
	input wire blockedRight,
	input wire blockedDown,
	input wire blockedRot,
	input wire gameOver,
	output pieceState_t piece,
	output pieceState_t rotPiece,
	output logic landed
);

	moverState_t state;
	logic [7:0] count; // gravity count, reused as lock delay
	logic [8:0] shapeCnt; // free running, feeds shape choice
	int threshold; // shrinks as difficulty rises
	logic countDone;

	assign threshold = gravityBase - 4 * int'(difficulty);
	assign countDone = (int'(count) >= threshold);

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
			shapeCnt <= '0;
		else if (shapeCnt == 9'd256)
			shapeCnt <= '0; // 0 to 256 then wrap
		else
			shapeCnt <= shapeCnt + 9'd1;
	end

	// ------------------------------
	// main state machine
	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			state <= idle;
			piece <= '0; // shape 0 means no piece
			count <= '0;
			landed <= 1'b0;
		end
		else
		begin
			landed <= 1'b0; // single cycle pulse
			case (state)
				idle:
					state <= spawn;
				spawn:
				begin
					if (gameOver)
						state <= over; // no room left
					else
					begin
						piece.row <= spawnRow;
						piece.col <= spawnCol;
						piece.rot <= '0;
						piece.shape <= shape_t'(shapeCnt % 9'd7) + shape_t'(1); // 1..7
						count <= '0;
						state <= fall;
					end
				end
				fall:
				begin
					if (keyCmd.moveLeft && !blockedLeft)
						piece.col <= piece.col - coord_t'(1);
					else if (keyCmd.moveRight && !blockedRight)
						piece.col <= piece.col + coord_t'(1);
					if (keyCmd.rotate && !blockedRot)
						piece.rot <= piece.rot + rot_t'(1); // 3 wraps to 0
					if (blockedDown)
					begin
						count <= '0; // start lock delay fresh
						state <= dwell;
					end
					else if (countDone)
					begin
						piece.row <= piece.row + coord_t'(1); // one row down
						count <= '0;
					end
					else if (keyCmd.drop)
						count <= count + 8'(dropStep); // fast fall
					else
						count <= count + 8'd1;
				end
				dwell:
				begin
					if (!blockedDown)
					begin
						count <= '0; // support went away
						state <= fall;
					end
					else if (countDone)
					begin
						landed <= 1'b1; // piece locks here
						count <= '0;
						state <= spawn;
					end
					else
						count <= count + 8'd1;
				end
				over:
					state <= over; // held until reset
				default:
					state <= idle;
			endcase
		end
	end

	always_comb
	begin
		rotPiece = piece;
		rotPiece.rot = piece.rot + rot_t'(1); // candidate for the rotate check
	end

endmodule

`default_nettype wire

/* src/pieceRasterizer.sv */
//------------------------------
// piece rasterizer
// four piece cells to a registered
// 20 by 10 occupancy grid
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module pieceRasterizer import tetrisPkg::*;
(
	input wire Reset, // clock
	input wire frame_clk, // async reset, active high
	input wire pieceCells_t cells,
	output board_t currBlocks
);

	cell_t [3:0] cellArr;
	board_t gridNext; // grid for the cells right now

	assign cellArr = cells;

	always_comb
	begin
		gridNext = '0;
		for (int r = 0; r < boardRows; r++)
		begin
			for (int c = 0; c < boardCols; c++)
			begin
				for (int i = 0; i < 4; i++)
				begin
					if (cellArr[i].row == coord_t'(r) && cellArr[i].col == coord_t'(c))
						gridNext[r][c] = 1'b1; // off-board cells never match
				end
			end
		end
	end

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
			currBlocks <= '0;
		else
			currBlocks <= gridNext; // one cycle behind the anchor
	end

endmodule

`default_nettype wire

/* src/currBlockTop.sv */
//------------------------------
// falling piece controller, top
// key decode, mover, shape and
// collision logic, grid output
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module currBlockTop import tetrisPkg::*;
#(
	parameter int gravityBase = 60,
	parameter int dropStep = 10
)
(
	input wire Reset, // clock
	input wire frame_clk, // async reset, active high
	input wire [7:0] keycode,
	input wire [3:0] difficulty,
	input wire board_t fallenBlocks, // landed cells from outside
	output board_t currBlocks,
	output shape_t shape,
	output coord_t xPos,
	output coord_t yPos,
	output logic landed,
	output logic lineBreak,
	output logic gameOver,
	output logic startGame
);

	keyCmd_t keyCmd;
	pieceState_t piece; // live piece
	pieceState_t rotPiece; // same piece turned once
	pieceCells_t cells;
	pieceCells_t rotCells;
	logic blockedLeft;
	logic blockedRight;
	logic blockedDown;
	logic blockedRot;

	// ------------------------------
	// input side
	keyDecoder keyDec_i (
		.Reset(Reset),
		.frame_clk(frame_clk),
		.keycode(keycode),
		.keyCmd(keyCmd),
		.startGame(startGame)
	);

	// ------------------------------
	// processing
	pieceMover #(
		.gravityBase(gravityBase),
		.dropStep(dropStep)
	) mover_i (
		.Reset(Reset),
		.frame_clk(frame_clk),
		.keyCmd(keyCmd),
		.difficulty(difficulty),
		.blockedLeft(blockedLeft),
		.blockedRight(blockedRight),
		.blockedDown(blockedDown),
		.blockedRot(blockedRot),
		.gameOver(gameOver),
		.piece(piece),
		.rotPiece(rotPiece),
		.landed(landed)
	);

	pieceShape shapeCur_i (.piece(piece), .cells(cells)); // current cells
	pieceShape shapeRot_i (.piece(rotPiece), .cells(rotCells)); // cells after a turn

	collisionCheck collide_i (
		.cells(cells),
		.rotCells(rotCells),
		.fallenBlocks(fallenBlocks),
		.blockedLeft(blockedLeft),
		.blockedRight(blockedRight),
		.blockedDown(blockedDown),
		.blockedRot(blockedRot),
		.lineBreak(lineBreak),
		.gameOver(gameOver)
	);

	// ------------------------------
	// output side
	pieceRasterizer raster_i (
		.Reset(Reset),
		.frame_clk(frame_clk),
		.cells(cells),
		.currBlocks(currBlocks)
	);

	assign shape = piece.shape;
	assign xPos = piece.col; // anchor column
	assign yPos = piece.row; // anchor row

endmodule

`default_nettype wire

/* verif/currBlock_chk.sv */
//------------------------------
// piece controller checker
// bound assertions on the top level
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module currBlock_chk import tetrisPkg::*;
(
	input wire Reset, // clock
	input wire frame_clk, // async reset
	input wire landed,
	input wire shape_t shape,
	input wire coord_t xPos,
	input wire coord_t yPos,
	input wire moverState_t moverState // taken from the mover FSM
);

	// lock pulse is a single cycle
	landedPulse: assert property (@(posedge Reset) disable iff (frame_clk)
		landed |=> !landed)
		else $error("landed held longer than one cycle");

	// a piece never vanishes once spawned
	shapeKept: assert property (@(posedge Reset) disable iff (frame_clk)
		(shape != shape_t'(0)) |=> (shape != shape_t'(0)))
		else $error("shape went back to none");

	// moves during fall are single steps
	colStep: assert property (@(posedge Reset) disable iff (frame_clk)
		(moverState == fall) |=> ((xPos == $past(xPos)) ||
			(xPos == $past(xPos) + coord_t'(1)) || (xPos == $past(xPos) - coord_t'(1))))
		else $error("column jumped by more than one");

	// frozen once the game is over
	overFrozen: assert property (@(posedge Reset) disable iff (frame_clk)
		(moverState == over) |=> ($stable(xPos) && $stable(yPos) && $stable(shape)))
		else $error("piece changed after game over");

endmodule

bind currBlockTop currBlock_chk chk_i (
	.Reset(Reset),
	.frame_clk(frame_clk),
	.landed(landed),
	.shape(shape),
	.xPos(xPos),
	.yPos(yPos),
	.moverState(mover_i.state)
);

`default_nettype wire

/* verif/currBlockTb.sv */
//------------------------------
// piece controller testbench
// key table, landing, row flags
// against a shape table model
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module currBlockTb import tetrisPkg::*;
();

	typedef struct {
		logic [7:0] key;
		int hold; // cycles the key stays down
		bit column; // landed column beside the piece
	} step_t;

	logic Reset; // clock
	logic frame_clk; // reset
	logic [7:0] keycode;
	logic [3:0] difficulty;
	board_t fallenBlocks;
	board_t currBlocks;
	shape_t shape;
	coord_t xPos;
	coord_t yPos;
	logic landed;
	logic lineBreak;
	logic gameOver;
	logic startGame;

	shape_t curShape; // model copy of the piece
	rot_t curRot;
	coord_t snapRow;
	coord_t snapCol;
	int slowCycles;
	int fastCycles;
	int n;
	int edgeCnt = 0; // rising edges since reset release

	step_t steps [0:23] = '{
		'{keyA, 5, 0}, '{keyA, 1, 0}, '{keyA, 1, 0}, '{keyA, 1, 0}, '{keyA, 1, 0},
		'{keyA, 1, 0}, '{keyW, 1, 0}, '{keyW, 1, 0}, '{keyD, 6, 0}, '{keyD, 1, 0},
		'{keyD, 1, 0}, '{keyD, 1, 0}, '{keyD, 1, 0}, '{keyD, 1, 0}, '{keyD, 1, 0},
		'{keyD, 1, 0}, '{keyW, 1, 0}, '{keyW, 1, 1}, '{keyW, 1, 0}, '{keyW, 1, 0},
		'{keyW, 1, 0}, '{keyS, 3, 0}, '{keySpace, 2, 0}, '{8'h00, 2, 0}
	};

	currBlockTop #(.gravityBase(60), .dropStep(10)) dut_i (
		.Reset(Reset), .frame_clk(frame_clk), .keycode(keycode),
		.difficulty(difficulty), .fallenBlocks(fallenBlocks),
		.currBlocks(currBlocks), .shape(shape), .xPos(xPos), .yPos(yPos),
		.landed(landed), .lineBreak(lineBreak), .gameOver(gameOver),
		.startGame(startGame)
	);

	initial
	begin
		Reset = 1'b0;
		forever #2 Reset = ~Reset; // 4 ns period
	end

	// shape counter runs from the first edge out of reset
	always @(posedge Reset)
	begin
		if (!frame_clk)
			edgeCnt <= edgeCnt + 1;
	end

	// ------------------------------
	// reference model
	function automatic shape_t expShape(int spawnEdge);
		return shape_t'(((spawnEdge - 1) % 257) % 7 + 1); // counter value before that edge
	endfunction

	function automatic board_t modelGrid(shape_t s, rot_t r, coord_t row, coord_t col);
		board_t g;
		int cr;
		int cc;
		g = '0;
		for (int i = 0; i < 4; i++)
		begin
			cr = int'(row) + int'(shapeOffsets[s][r][i][0]);
			cc = int'(col) + int'(shapeOffsets[s][r][i][1]);
			if (cr >= 0 && cr < boardRows && cc >= 0 && cc < boardCols)
				g[cr][cc] = 1'b1; // visible cells only
		end
		return g;
	endfunction

	function automatic bit fits(shape_t s, rot_t r, coord_t row, coord_t col, board_t fb);
		int cr;
		int cc;
		for (int i = 0; i < 4; i++)
		begin
			cr = int'(row) + int'(shapeOffsets[s][r][i][0]);
			cc = int'(col) + int'(shapeOffsets[s][r][i][1]);
			if (cc < 0 || cc >= boardCols || cr >= boardRows)
				return 1'b0; // off the sides or under the floor
			if (cr >= 0 && fb[cr][cc])
				return 1'b0; // on a landed cell
		end
		return 1'b1;
	endfunction

	// column from row 1 down that the piece does not touch but its next turn hits
	function automatic board_t blockColumn(shape_t s, rot_t r, coord_t row, coord_t col);
		board_t cur;
		board_t fb;
		bit touch;
		cur = modelGrid(s, r, row, col);
		for (int cc = 0; cc < boardCols; cc++)
		begin
			fb = '0;
			touch = 1'b0;
			for (int rr = 0; rr < boardRows; rr++)
			begin
				if (rr > 0)
					fb[rr][cc] = 1'b1;
				if (cur[rr][cc])
					touch = 1'b1; // would rest on it or overlap
			end
			if (!touch && !fits(s, r + rot_t'(1), row, col, fb))
				return fb;
		end
		return '0;
	endfunction

	function automatic bit allVisible(shape_t s, coord_t row);
		for (int r = 0; r < 4; r++)
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (int'(row) + int'(shapeOffsets[s][r][i][0]) < 0)
					return 1'b0; // some turn still pokes above row 0
			end
		end
		return 1'b1;
	endfunction

	function automatic int lowestRow(shape_t s, rot_t r, coord_t row);
		int low;
		low = -100;
		for (int i = 0; i < 4; i++)
		begin
			if (int'(row) + int'(shapeOffsets[s][r][i][0]) > low)
				low = int'(row) + int'(shapeOffsets[s][r][i][0]);
		end
		return low;
	endfunction

	// ------------------------------
	// compare tasks
	task automatic stopFail(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkCoord(input string name, input coord_t got, input coord_t exp);
		if (got !== exp)
			stopFail($sformatf("error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	task automatic checkShape(input string name, input shape_t got, input shape_t exp);
		if (got !== exp)
			stopFail($sformatf("error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	task automatic checkBoard(input string name, input board_t got, input board_t exp);
		if (got !== exp)
			stopFail($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stopFail($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	task automatic waitLanded(input int limit, output int cycles);
		cycles = 0;
		while (!landed)
		begin
			if (cycles >= limit)
				stopFail("timeout: the piece never landed");
			@(posedge Reset);
			#1;
			cycles++;
		end
	endtask

	// one table row: key press, hold, release, then compare
	task automatic applyStep(input logic [7:0] key, input int hold, input bit column);
		coord_t row0;
		coord_t col0;
		coord_t expCol;
		rot_t expRot;
		board_t fb;
		fb = '0;
		if (column)
		begin
			fb = blockColumn(curShape, curRot, yPos, xPos);
			if (fb == '0)
				stopFail("no landed column can block the next turn of this piece");
		end
		else
			fb[boardRows-1] = boardRow_t'($urandom % 1023); // never a full row
		fallenBlocks = fb;
		difficulty = 4'($urandom % 4);
		keycode = key;
		row0 = yPos; // state seen by the next edge
		col0 = xPos;
		expCol = col0;
		expRot = curRot;
		if (key == keyA && fits(curShape, curRot, row0, col0 - coord_t'(1), fb))
			expCol = col0 - coord_t'(1);
		if (key == keyD && fits(curShape, curRot, row0, col0 + coord_t'(1), fb))
			expCol = col0 + coord_t'(1);
		if (key == keyW && fits(curShape, curRot + rot_t'(1), row0, col0, fb))
			expRot = curRot + rot_t'(1);
		#1;
		checkBit("startGame", startGame, key != 8'h00);
		checkBit("lineBreak", lineBreak, 1'b0); // no full row in the table
		checkBit("gameOver", gameOver, 1'b0);
		checkBit("landed", landed, 1'b0);
		repeat (hold) @(posedge Reset);
		#1 keycode = 8'h00;
		@(posedge Reset);
		#1;
		snapRow = yPos;
		snapCol = expCol;
		checkCoord("xPos", xPos, expCol);
		checkShape("shape", shape, curShape);
		@(posedge Reset);
		#1;
		checkBoard("currBlocks", currBlocks, modelGrid(curShape, expRot, snapRow, snapCol));
		curRot = expRot;
	endtask

	// ------------------------------
	// main sequence
	initial
	begin
		void'($urandom(32'hed32));
		frame_clk = 1'b1;
		keycode = 8'h00;
		difficulty = 4'd0;
		fallenBlocks = '0;
		repeat (4) @(posedge Reset);
		#1 frame_clk = 1'b0;
		n = 0;
		while (shape == shape_t'(0))
		begin
			if (n >= 20)
				stopFail("timeout: no piece spawned after reset");
			@(posedge Reset);
			#1;
			n++;
		end
		checkBit("shape valid", shape >= shape_t'(1) && shape <= shape_t'(7), 1'b1);
		curShape = expShape(edgeCnt);
		checkShape("shape", shape, curShape);
		checkCoord("yPos", yPos, spawnRow);
		checkCoord("xPos", xPos, spawnCol);
		curRot = '0;
		// fall until every turn of the piece is on the board
		n = 0;
		while (!allVisible(curShape, yPos))
		begin
			if (n >= 400)
				stopFail("timeout: the piece never came into view");
			@(posedge Reset);
			#1;
			n++;
		end
		checkCoord("xPos", xPos, spawnCol);
		snapRow = yPos;
		snapCol = spawnCol;
		@(posedge Reset);
		#1;
		checkBoard("currBlocks", currBlocks, modelGrid(curShape, curRot, snapRow, snapCol));
		for (int k = 0; k < $size(steps); k++)
			applyStep(steps[k].key, steps[k].hold, steps[k].column);
		// gravity on an empty board
		fallenBlocks = '0;
		difficulty = 4'd3;
		waitLanded(4000, n);
		checkCoord("lowest row", coord_t'(lowestRow(curShape, curRot, yPos)), 19);
		@(posedge Reset);
		#1;
		checkCoord("yPos", yPos, spawnRow);
		checkCoord("xPos", xPos, spawnCol);
		curShape = expShape(edgeCnt);
		checkShape("shape", shape, curShape);
		curRot = '0;
		waitLanded(4000, slowCycles);
		checkCoord("lowest row", coord_t'(lowestRow(curShape, curRot, yPos)), 19);
		@(posedge Reset);
		#1 keycode = keyS; // drop held for the whole fall
		checkShape("shape", shape, expShape(edgeCnt));
		waitLanded(4000, fastCycles);
		checkBit("drop is faster", fastCycles < slowCycles, 1'b1);
		keycode = 8'h00;
		@(posedge Reset);
		#1 fallenBlocks[10] = '1; // one complete row
		#1;
		checkBit("lineBreak", lineBreak, 1'b1);
		checkBit("gameOver", gameOver, 1'b0);
		@(posedge Reset);
		#1;
		fallenBlocks = '0;
		fallenBlocks[0] = boardRow_t'(1); // top row taken at column 0
		keycode = keyS;
		#1;
		checkBit("lineBreak", lineBreak, 1'b0);
		checkBit("gameOver", gameOver, 1'b1);
		waitLanded(4000, n);
		snapRow = yPos; // resting row of the last piece
		repeat (60)
		begin
			@(posedge Reset);
			#1;
			checkCoord("yPos after game over", yPos, snapRow);
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* currBlockTop.f */
src/tetrisPkg.sv
src/keyDecoder.sv
src/pieceShape.sv
src/collisionCheck.sv
src/pieceMover.sv
src/pieceRasterizer.sv
src/currBlockTop.sv
verif/currBlock_chk.sv
verif/currBlockTb.sv

/* run.sh */
#!/bin/sh
# build and run the piece controller testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f currBlockTop.f --top-module currBlockTb
./obj_dir/VcurrBlockTb > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi
grep -q "Simulation finished: PASS" sim.log
